//--- sources.f
src/cache_pkg.sv
src/set_array.sv
src/cpu_req_stage.sv
src/way_lookup.sv
src/cache_fsm.sv
src/mem_port.sv
src/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the cache testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module cache_tb -Mdir obj_dir -f sources.f
	./obj_dir/Vcache_tb | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
  import cache_pkg::*;

  logic      clk;
  logic      rst_n;
  logic      cpu_req_valid;
  cpu_req_t  cpu_req;
  logic      cpu_ready;
  logic      cpu_resp_valid;
  cpu_resp_t cpu_resp;
  logic      mem_req_valid;
  mem_req_t  mem_req;
  logic      mem_ready;
  block_t    mem_rdata;
  logic      accept;

  // Expectations for the request in flight, moved on the issue edge
  logic        exp_hit;
  logic        exp_read;
  logic        exp_evict;
  word_t       exp_rdata;
  blk_addr_t   exp_fill_addr;
  blk_addr_t   exp_wb_addr;
  block_t      exp_wb_block;
  int unsigned wb_base;
  int unsigned fill_base;

  int unsigned wb_count;     // Completed write-backs
  int unsigned fill_count;   // Completed fills
  int unsigned outstanding;  // Accepted but not yet answered
  int unsigned errors;
  int unsigned timeouts;
  int unsigned wait_limit = 200;

  line_meta_t  model_meta [num_sets][num_ways]; // Tags and ages as the cache should hold them
  word_t       ref_mem [bit [31:0]];            // CPU view of memory, written words only

  assign accept = cpu_req_valid && cpu_ready;

  cache_top dut0 (
    .clk, .rst_n, .cpu_req_valid, .cpu_req, .cpu_ready, .cpu_resp_valid, .cpu_resp,
    .mem_req_valid, .mem_req, .mem_ready, .mem_rdata
  );

  mem_model mem0 (.clk, .rst_n, .mem_req_valid, .mem_req, .mem_ready, .mem_rdata);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_count    <= 0;
      fill_count  <= 0;
      outstanding <= 0;
    end else begin
      if (mem_req_valid && mem_ready) begin
        if (mem_req.write) wb_count <= wb_count + 1;
        else fill_count <= fill_count + 1;
      end
      outstanding <= outstanding + 32'(accept) - 32'(cpu_resp_valid);
    end
  end

  function automatic void flag_error(input string msg);
    errors++;
    $display("%s", msg);
  endfunction

  function automatic word_t ref_word(input logic [31:0] a);
    if (ref_mem.exists(a)) return ref_mem[a];
    return a ^ 32'h5a5a_5a5a; // Same start pattern as the memory
  endfunction

  // LRU model: hit way to age 0, younger lines age; a miss ages every valid line
  task automatic predict(input logic wr, input logic [31:0] a, input word_t wdata);
    word_addr_t wa;
    line_meta_t m [num_ways];
    int         hit_way;
    int         vic;
    age_t       old_age;
    block_t     wb_block;
    logic       evict;
    wa       = a;
    m        = model_meta[wa.index];
    hit_way  = -1;
    vic      = -1;
    evict    = 1'b0;
    wb_block = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (m[w].valid && m[w].tag == wa.tag) hit_way = w;
    end
    if (hit_way >= 0) begin
      old_age = m[hit_way].age;
      for (int w = 0; w < num_ways; w++) begin
        if (m[w].valid && m[w].age < old_age) m[w].age = m[w].age + 1'b1;
      end
      m[hit_way].age = '0;
      if (wr) m[hit_way].dirty = 1'b1;
    end else begin
      for (int w = 0; w < num_ways; w++) begin
        if (!m[w].valid && vic < 0) vic = w; // First empty way
      end
      if (vic < 0) begin
        for (int w = 0; w < num_ways; w++) begin
          if (m[w].age == age_t'(age_oldest)) vic = w;
        end
      end
      if (m[vic].valid && m[vic].dirty) begin
        evict = 1'b1;
        for (int o = 0; o < words_per_block; o++) begin
          wb_block[o*word_bits +: word_bits] = ref_word({m[vic].tag, wa.index, offset_t'(o)});
        end
      end
      exp_wb_addr <= {m[vic].tag, wa.index};
      for (int w = 0; w < num_ways; w++) begin
        if (m[w].valid && w != vic) m[w].age = m[w].age + 1'b1;
      end
      m[vic] = '{valid: 1'b1, dirty: wr, age: '0, tag: wa.tag};
    end
    exp_hit       <= (hit_way >= 0);
    exp_read      <= !wr;
    exp_evict     <= evict;
    exp_rdata     <= ref_word(a);
    exp_fill_addr <= {wa.tag, wa.index};
    exp_wb_block  <= wb_block;
    wb_base       <= wb_count;
    fill_base     <= fill_count;
    if (wr) ref_mem[a] = wdata;
    model_meta[wa.index] = m;
  endtask

  // One CPU transfer, issued on a rising edge, watched on falling edges
  task automatic access(input logic wr, input tag_t tag, input index_t idx,
                        input offset_t off, input word_t wdata);
    logic [31:0] a;
    int unsigned n;
    if (timeouts != 0) return; // Run already failed
    a = {tag, idx, off};
    @(posedge clk);
    predict(wr, a, wdata);
    cpu_req_valid <= 1'b1;
    cpu_req       <= {wr, a, wdata};
    n = 0;
    @(negedge clk);
    while (!cpu_ready && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!cpu_ready) begin
      timeouts++;
      $display("Timeout: cpu_ready stayed low for %0d cycles", wait_limit);
      return;
    end
    @(posedge clk);          // Accept edge, valid stays up while the cache is busy
    n = 0;
    @(negedge clk);
    while (!cpu_resp_valid && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!cpu_resp_valid) begin
      timeouts++;
      $display("Timeout: no response to the request at address %h", a);
    end
  endtask

  assert property (@(posedge clk) $rose(rst_n) |-> (cpu_ready && !mem_req_valid && !cpu_resp_valid))
    else flag_error("Outputs not idle after reset");

  assert property (@(posedge clk) disable iff (!rst_n)
    (cpu_resp_valid && exp_read) |-> (cpu_resp.rdata == exp_rdata))
    else flag_error($sformatf("MISMATCH cpu_resp.rdata got %h expected %h",
                              $sampled(cpu_resp.rdata), $sampled(exp_rdata)));

  // Hit answers on the second edge after accept
  assert property (@(posedge clk) disable iff (!rst_n)
    ($past(accept) && exp_hit) |-> !cpu_resp_valid)
    else flag_error("Hit response came one edge after accept");
  assert property (@(posedge clk) disable iff (!rst_n)
    ($past(accept, 2) && exp_hit) |-> cpu_resp_valid)
    else flag_error("Hit response missing two edges after accept");
  assert property (@(posedge clk) disable iff (!rst_n) exp_hit |-> !mem_req_valid)
    else flag_error("Memory request issued for a hit");

  // Write-back goes out with the victim's address and newest data
  assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_valid && mem_req.write) |-> exp_evict)
    else flag_error("Memory write-back without a dirty victim");
  assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_valid && mem_req.write) |-> (mem_req.addr == exp_wb_addr))
    else flag_error($sformatf("MISMATCH mem_req.addr got %h expected %h",
                              $sampled(mem_req.addr), $sampled(exp_wb_addr)));
  assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_valid && mem_req.write) |-> (mem_req.block == exp_wb_block))
    else flag_error($sformatf("MISMATCH mem_req.block got %h expected %h",
                              $sampled(mem_req.block), $sampled(exp_wb_block)));
  assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_valid && !mem_req.write) |-> (mem_req.addr == exp_fill_addr))
    else flag_error($sformatf("MISMATCH mem_req.addr got %h expected %h",
                              $sampled(mem_req.addr), $sampled(exp_fill_addr)));

  // Exactly the expected number of memory transfers per request
  assert property (@(posedge clk) disable iff (!rst_n)
    cpu_resp_valid |-> ((wb_count - wb_base) == 32'(exp_evict)))
    else flag_error($sformatf("MISMATCH write-back count got %h expected %h",
                              $sampled(wb_count - wb_base), $sampled(exp_evict)));
  assert property (@(posedge clk) disable iff (!rst_n)
    cpu_resp_valid |-> ((fill_count - fill_base) == 32'(!exp_hit)))
    else flag_error($sformatf("MISMATCH fill count got %h expected %h",
                              $sampled(fill_count - fill_base), $sampled(!exp_hit)));

  // Back-pressure holds the request and the CPU side
  assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_valid && !mem_ready) |=> $stable(mem_req))
    else flag_error("mem_req changed while mem_ready was low");
  assert property (@(posedge clk) disable iff (!rst_n) mem_req_valid |-> !cpu_ready)
    else flag_error("cpu_ready high during a memory transfer");
  assert property (@(posedge clk) disable iff (!rst_n) cpu_resp_valid |-> (outstanding == 1))
    else flag_error("Response without exactly one pending request");
  assert property (@(posedge clk) disable iff (!rst_n) accept |-> (outstanding == 0))
    else flag_error("Request accepted before the previous one was answered");

  initial begin
    void'($urandom(32'hdbe6_e3ab));
    errors   = 0;
    timeouts = 0;
    for (int s = 0; s < num_sets; s++) begin
      for (int w = 0; w < num_ways; w++) model_meta[s][w] = '0;
    end
    rst_n         <= 1'b0;
    cpu_req_valid <= 1'b0;
    cpu_req       <= '0;
    exp_hit       <= 1'b0;
    exp_read      <= 1'b0;
    exp_evict     <= 1'b0;
    exp_rdata     <= '0;
    exp_fill_addr <= '0;
    exp_wb_addr   <= '0;
    exp_wb_block  <= '0;
    wb_base       <= 0;
    fill_base     <= 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Miss, then hits on the resident block
    access(1'b1, 26'h000_0abc, 4'd0, 2'd1, 32'h1234_5678);
    access(1'b0, 26'h000_0abc, 4'd0, 2'd1, 32'h0);
    access(1'b0, 26'h000_0abc, 4'd0, 2'd3, 32'h0);

    // Dirty A to D in set 9, touch A, then E pushes out B
    for (int i = 0; i < 4; i++) begin
      access(1'b1, tag_t'(26'h3_0000 + i), 4'd9, offset_t'(i), $urandom);
    end
    access(1'b0, 26'h3_0000, 4'd9, 2'd0, 32'h0);
    access(1'b0, 26'h3_0004, 4'd9, 2'd2, 32'h0);

    // Clean victim once set 12 is full of reads
    for (int i = 0; i < 5; i++) begin
      access(1'b0, tag_t'(26'h100 + i), 4'd12, offset_t'(i), 32'h0);
    end

    // Mixed traffic, six tags over three sets
    for (int i = 0; i < 300; i++) begin
      access($urandom_range(1, 0) == 1, tag_t'(26'h200 + $urandom_range(5, 0)),
             index_t'(1 + $urandom_range(2, 0)), offset_t'($urandom_range(3, 0)), $urandom);
    end

    @(posedge clk);
    cpu_req_valid <= 1'b0; // Last response edge, nothing more to send
    repeat (2) @(posedge clk);
    $display("Summary: %0d assertion errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- bench/mem_model.sv
`timescale 1ns/1ps

// Block memory behind the cache, each request stalls 0 to 5 extra cycles
module mem_model (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                mem_req_valid,
  input  cache_pkg::mem_req_t mem_req,
  output logic                mem_ready,
  output cache_pkg::block_t   mem_rdata
);
  import cache_pkg::*;

  block_t      store [bit [tag_bits+index_bits-1:0]]; // Written blocks only
  logic        busy_q;  // Current request already has its delay
  int unsigned wait_q;  // Stall cycles left

  // Unwritten words follow their word address
  function automatic block_t read_block(input blk_addr_t a);
    block_t b;
    if (store.exists(a)) return store[a];
    for (int o = 0; o < words_per_block; o++) begin
      b[o*word_bits +: word_bits] = {a, offset_t'(o)} ^ 32'h5a5a_5a5a;
    end
    return b;
  endfunction

  assign mem_ready = mem_req_valid && busy_q && (wait_q == 0); // Read data already staged

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      wait_q    <= 0;
      mem_rdata <= '0;
    end else if (mem_ready) begin
      busy_q <= 1'b0; // Handshake on this edge
      if (mem_req.write) store[mem_req.addr] = mem_req.block;
    end else if (mem_req_valid && !busy_q) begin
      busy_q    <= 1'b1;
      wait_q    <= $urandom_range(5, 0);
      mem_rdata <= read_block(mem_req.addr);
    end else if (wait_q != 0) begin
      wait_q <= wait_q - 1;
    end
  end

endmodule

//--- src/cache_top.sv
`timescale 1ns/1ps

// Four-way write-back data cache, CPU word port and memory block port
module cache_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cpu_req_valid,
  input  cache_pkg::cpu_req_t  cpu_req,
  output logic                 cpu_ready,
  output logic                 cpu_resp_valid,
  output cache_pkg::cpu_resp_t cpu_resp,
  output logic                 mem_req_valid,
  output cache_pkg::mem_req_t  mem_req,
  input  logic                 mem_ready,
  input  cache_pkg::block_t    mem_rdata
);
  import cache_pkg::*;

  logic      accept;
  tag_t      req_tag;
  index_t    req_index;
  offset_t   req_offset;
  logic      req_write;
  word_t     req_wdata;
  meta_set_t meta_rd;
  meta_set_t new_meta;
  data_set_t data_rd;
  data_set_t data_wr;
  way_mask_t way_sel;
  way_mask_t meta_mask;
  way_mask_t data_mask;
  logic      hit;
  logic      victim_dirty;
  tag_t      victim_tag;
  block_t    victim_block;
  block_t    new_block;
  block_t    fill_block;
  word_t     rdata;
  logic      mem_start_write;
  logic      mem_start_read;
  logic      mem_done;
  logic      array_write;
  blk_addr_t req_blk_addr;

  assign accept       = cpu_req_valid && cpu_ready;
  assign meta_mask    = {num_ways{array_write}};  // Ages may move in every way
  assign data_mask    = way_sel & meta_mask;      // Only the selected block
  assign data_wr      = {num_ways{new_block}};
  assign req_blk_addr = {req_tag, req_index};
  assign cpu_resp.rdata = rdata;

  cpu_req_stage u_req (
    .clk, .rst_n, .accept, .cpu_req,
    .req_tag, .req_index, .req_offset, .req_write, .req_wdata
  );

  set_array #(.entry_t(line_meta_t)) meta_array (
    .clk, .rst_n,
    .rd_index (req_index),
    .rd_ways  (meta_rd),
    .wr_index (req_index),
    .wr_mask  (meta_mask),
    .wr_ways  (new_meta)
  );

  set_array #(.entry_t(block_t)) data_array (
    .clk, .rst_n,
    .rd_index (req_index),
    .rd_ways  (data_rd),
    .wr_index (req_index),
    .wr_mask  (data_mask),
    .wr_ways  (data_wr)
  );

  way_lookup u_lookup (
    .meta (meta_rd), .blocks (data_rd),
    .req_tag, .req_offset, .req_write, .req_wdata, .fill_block,
    .hit, .way_sel, .victim_dirty,
    .victim_addr (victim_tag),
    .victim_block, .new_meta, .new_block, .rdata
  );

  cache_fsm u_fsm (
    .clk, .rst_n, .cpu_req_valid, .cpu_ready, .hit, .victim_dirty,
    .mem_start_write, .mem_start_read,
    .mem_done, .array_write, .cpu_resp_valid
  );

  mem_port u_mem (
    .clk, .rst_n,
    .start_write (mem_start_write),
    .start_read  (mem_start_read),
    .victim_addr (victim_tag),
    .victim_block,
    .req_addr    (req_blk_addr),
    .mem_req_valid, .mem_req, .mem_ready, .mem_rdata,
    .done        (mem_done),
    .fill_block
  );

  // Update must always land in exactly one way of the data array
  assert property (@(posedge clk) disable iff (!rst_n)
    array_write |-> $onehot(way_sel))
    else $error("cache_top: update without a single target way");

endmodule

//--- src/mem_port.sv
`timescale 1ns/1ps

// Memory side request register with valid/ready handshake
module mem_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_write,
  input  logic                 start_read,
  input  cache_pkg::tag_t      victim_addr,
  input  cache_pkg::block_t    victim_block,
  input  cache_pkg::blk_addr_t req_addr,     // Block address of the CPU request
  output logic                 mem_req_valid,
  output cache_pkg::mem_req_t  mem_req,
  input  logic                 mem_ready,
  input  cache_pkg::block_t    mem_rdata,
  output logic                 done,
  output cache_pkg::block_t    fill_block
);

  assign done = mem_req_valid && mem_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_req_valid <= 1'b0;
    end else if (start_write || start_read) begin
      mem_req_valid <= 1'b1;
    end else if (done) begin
      mem_req_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_write) begin
      mem_req.write      <= 1'b1;
      mem_req.addr.tag   <= victim_addr;   // Victim lives in the request's set
      mem_req.addr.index <= req_addr.index;
      mem_req.block      <= victim_block;
    end else if (start_read) begin
      mem_req.write <= 1'b0;
      mem_req.addr  <= req_addr;
      mem_req.block <= '0;
    end
    if (done && !mem_req.write) begin
      fill_block <= mem_rdata; // Read data arrives with ready
    end
  end

  // Request must not move while memory stalls
  assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_valid && !mem_ready) |=> (mem_req_valid && $stable(mem_req)))
    else $error("mem_port: request changed under back-pressure");

endmodule

//--- src/cache_fsm.sv
`timescale 1ns/1ps

// Controller sequencing, lookup then optional write-back and fill
module cache_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic cpu_req_valid,
  output logic cpu_ready,
  input  logic hit,
  input  logic victim_dirty,
  output logic mem_start_write,  // Loads a write-back into the memory port
  output logic mem_start_read,   // Loads a fill request
  input  logic mem_done,
  output logic array_write,
  output logic cpu_resp_valid
);
  import cache_pkg::*;

  cache_state_t state_q;
  cache_state_t state_d;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d         = state_q;
    mem_start_write = 1'b0;
    mem_start_read  = 1'b0;
    case (state_q)
      idle: begin
        if (cpu_req_valid) state_d = lookup; // Arrays read on this edge
      end
      lookup: begin
        if (hit) begin
          state_d = update;
        end else if (victim_dirty) begin
          state_d         = evict;
          mem_start_write = 1'b1;
        end else begin
          state_d        = allocate; // Clean or empty victim, straight to fill
          mem_start_read = 1'b1;
        end
      end
      evict: begin
        if (mem_done) begin
          state_d        = allocate;
          mem_start_read = 1'b1;     // Back-to-back with the write-back
        end
      end
      allocate: begin
        if (mem_done) state_d = update; // Fill block captured on this edge
      end
      update: begin
        state_d = idle;
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  assign cpu_ready      = (state_q == idle);
  assign array_write    = (state_q == update); // Meta and data written together
  assign cpu_resp_valid = (state_q == update);

  assert property (@(posedge clk) disable iff (!rst_n)
    cpu_resp_valid |=> !cpu_resp_valid)
    else $error("cache_fsm: response held longer than one cycle");

  // Memory port may only complete while a transfer is awaited
  assert property (@(posedge clk) disable iff (!rst_n)
    mem_done |-> (state_q inside {evict, allocate}))
    else $error("cache_fsm: memory handshake outside evict/allocate");

endmodule

//--- src/way_lookup.sv
`timescale 1ns/1ps

// Hit detection, victim pick, LRU ages and word merge, all combinational
module way_lookup (
  input  cache_pkg::meta_set_t meta,
  input  cache_pkg::data_set_t blocks,
  input  cache_pkg::tag_t      req_tag,
  input  cache_pkg::offset_t   req_offset,
  input  logic                 req_write,
  input  cache_pkg::word_t     req_wdata,
  input  cache_pkg::block_t    fill_block,   // Block returned by memory on a miss
  output logic                 hit,
  output cache_pkg::way_mask_t way_sel,      // Hit way, else victim
  output logic                 victim_dirty,
  output cache_pkg::tag_t      victim_addr,  // Victim tag, index is the request's
  output cache_pkg::block_t    victim_block,
  output cache_pkg::meta_set_t new_meta,
  output cache_pkg::block_t    new_block,
  output cache_pkg::word_t     rdata
);
  import cache_pkg::*;

  way_mask_t hit_vec;
  way_mask_t victim_vec;
  way_idx_t  sel_way;
  age_t      hit_age;
  logic      found_free;
  block_t    base_block;

  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      hit_vec[w] = meta[w].valid && (meta[w].tag == req_tag);
    end
  end

  assign hit = |hit_vec;

  // First invalid way wins, otherwise the oldest line
  always_comb begin
    victim_vec = '0;
    found_free = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      if (!meta[w].valid && !found_free) begin
        victim_vec[w] = 1'b1;
        found_free    = 1'b1;
      end
    end
    if (!found_free) begin
      for (int w = 0; w < num_ways; w++) begin
        victim_vec[w] = (meta[w].age == age_t'(age_oldest));
      end
    end
  end

  assign way_sel = hit ? hit_vec : victim_vec;

  always_comb begin
    sel_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (way_sel[w]) sel_way = way_idx_t'(w); // One-hot to index
    end
  end

  assign hit_age      = meta[sel_way].age;
  assign victim_dirty = meta[sel_way].valid && meta[sel_way].dirty;
  assign victim_addr  = meta[sel_way].tag;
  assign victim_block = blocks[sel_way];

  // Selected way becomes youngest; on a hit only younger lines age,
  // on a miss every valid line ages
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      new_meta[w] = meta[w];
      if (way_sel[w]) begin
        new_meta[w].valid = 1'b1;
        new_meta[w].dirty = req_write || (hit && meta[w].dirty); // Read fill comes in clean
        new_meta[w].age   = '0;
        new_meta[w].tag   = req_tag;
      end else if (meta[w].valid && (!hit || (meta[w].age < hit_age))) begin
        new_meta[w].age = meta[w].age + 1'b1;
      end
    end
  end

  // Merge base is the resident block on a hit, the fill otherwise
  always_comb begin
    base_block = hit ? blocks[sel_way] : fill_block;
    new_block  = base_block;
    if (req_write) begin
      new_block[req_offset*word_bits +: word_bits] = req_wdata;
    end
  end

  assign rdata = base_block[req_offset*word_bits +: word_bits];

  // Duplicate tags in one set would mean a broken allocation
  always_comb begin
    if (!$isunknown(hit_vec)) begin
      assert ($onehot0(hit_vec))
        else $error("way_lookup: tag %h hits in several ways", req_tag);
    end
  end

endmodule

//--- src/cpu_req_stage.sv
`timescale 1ns/1ps

// Holds the accepted CPU request for the whole transaction
module cpu_req_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                accept,     // valid && ready
  input  cache_pkg::cpu_req_t cpu_req,
  output cache_pkg::tag_t     req_tag,
  output cache_pkg::index_t   req_index,
  output cache_pkg::offset_t  req_offset,
  output logic                req_write,
  output cache_pkg::word_t    req_wdata
);
  import cache_pkg::*;

  cpu_req_t held_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      held_q <= cpu_req;
    end
  end

  assign req_tag    = held_q.addr.tag;
  assign req_offset = held_q.addr.offset;
  assign req_write  = held_q.write;
  assign req_wdata  = held_q.wdata;

  // Index bypasses the register in the accept cycle
  // so both arrays start their read on the accept edge
  assign req_index = accept ? cpu_req.addr.index : held_q.addr.index;

  // CPU must present a fully known request when it is taken
  assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> !$isunknown(cpu_req))
    else $error("cpu_req_stage: X on cpu_req at accept");

endmodule

//--- src/set_array.sv
`timescale 1ns/1ps

// Ways x sets storage, whole set read out one cycle after the index
module set_array #(
  parameter type entry_t = logic
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  cache_pkg::index_t                   rd_index,
  output entry_t [cache_pkg::num_ways-1:0]    rd_ways,
  input  cache_pkg::index_t                   wr_index,
  input  cache_pkg::way_mask_t                wr_mask,
  input  entry_t [cache_pkg::num_ways-1:0]    wr_ways
);
  import cache_pkg::*;

  entry_t [num_ways-1:0] sets_q [num_sets]; // One row per set

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < num_sets; s++) begin
        sets_q[s] <= '0; // Every line invalid, age 0
      end
      rd_ways <= '0;
    end else begin
      rd_ways <= sets_q[rd_index]; // Old contents on a same-edge write
      for (int w = 0; w < num_ways; w++) begin
        if (wr_mask[w]) begin
          sets_q[wr_index][w] <= wr_ways[w];
        end
      end
    end
  end

  // A masked write must name a known set
  assert property (@(posedge clk) disable iff (!rst_n)
    (wr_mask != '0) |-> !$isunknown(wr_index))
    else $error("set_array: write to unknown index");

endmodule

//--- src/cache_pkg.sv
package cache_pkg;

  // Sizes
  localparam int word_bits       = 32;
  localparam int words_per_block = 4;
  localparam int offset_bits     = $clog2(words_per_block);    // 2
  localparam int num_sets        = 16;
  localparam int index_bits      = $clog2(num_sets);           // 4
  localparam int num_ways        = 4;
  localparam int way_bits        = $clog2(num_ways);
  localparam int age_bits        = 2;
  localparam int age_oldest      = (1 << age_bits) - 1;        // LRU candidate age
  localparam int tag_bits        = word_bits - index_bits - offset_bits; // 26, word address
  localparam int block_bits      = word_bits * words_per_block; // 128

  typedef logic [word_bits-1:0]   word_t;
  typedef logic [block_bits-1:0]  block_t;
  typedef logic [tag_bits-1:0]    tag_t;
  typedef logic [index_bits-1:0]  index_t;
  typedef logic [offset_bits-1:0] offset_t;
  typedef logic [age_bits-1:0]    age_t;
  typedef logic [num_ways-1:0]    way_mask_t; // One bit per way
  typedef logic [way_bits-1:0]    way_idx_t;

  // Per-line bookkeeping, 30 bits
  typedef struct packed {
    logic valid;
    logic dirty;
    age_t age;   // 0 is most recently used
    tag_t tag;
  } line_meta_t;

  typedef line_meta_t [num_ways-1:0] meta_set_t; // All ways of one set
  typedef block_t [num_ways-1:0]     data_set_t;

  // Word address split as the cache sees it
  typedef struct packed {
    tag_t    tag;
    index_t  index;
    offset_t offset;
  } word_addr_t;

  typedef struct packed {
    tag_t   tag;
    index_t index;
  } blk_addr_t;

  typedef struct packed {
    logic       write; // 1 = store, 0 = load
    word_addr_t addr;
    word_t      wdata;
  } cpu_req_t;

  typedef struct packed {
    word_t rdata;
  } cpu_resp_t;

  typedef struct packed {
    logic      write; // 1 = write-back, 0 = fill
    blk_addr_t addr;
    block_t    block;
  } mem_req_t;

  typedef enum logic [2:0] {
    idle,
    lookup,
    evict,
    allocate,
    update
  } cache_state_t;

endpackage
